// ==== compile.f ====
des_types_pkg.sv
des_tables_pkg.sv
des_sbox_bank.sv
des_round.sv
des_key_schedule.sv
des_control.sv
des_engine_top.sv
tb_des_engine.sv

// ==== des_control.sv ====
`timescale 1ns/1ps

module des_control #(
	parameter int SINK_CREDITS = 2
) (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	output logic in_credit,
	input logic out_credit,
	output logic out_valid,
	output logic load,
	output logic step_sbox,
	output logic step_mix,
	output logic unload,
	output logic key_step,
	output logic [3:0] round_idx,
	output logic decrypt,
	input des_types_pkg::des_mode_e in_mode
);
	import des_types_pkg::*;

	localparam int cnt_w = $clog2(SINK_CREDITS + 1);

	des_phase_e phase;
	logic [3:0] round_q;
	logic decrypt_q;
	logic [cnt_w-1:0] sink_cnt;
	logic last_round;

	assign last_round = (round_q == 4'd15);
	assign load = (phase == ph_load) && in_valid;
	assign step_sbox = (phase == ph_sbox);
	assign step_mix = (phase == ph_mix);
	assign key_step = step_mix; // key registers rotate alongside the Feistel update
	assign unload = step_mix && last_round;
	assign out_valid = (phase == ph_done) && (sink_cnt != '0);
	assign round_idx = round_q;
	assign decrypt = load ? (in_mode == mode_decrypt) : decrypt_q; // mode is not latched yet during load

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase <= ph_idle;
			round_q <= '0;
			decrypt_q <= 1'b0;
			in_credit <= 1'b0;
		end else begin
			in_credit <= (phase == ph_idle) || out_valid; // one credit out of reset and per result
			case (phase)
				ph_idle: begin
					phase <= ph_load;
				end
				ph_load: begin
					if (in_valid) begin
						phase <= ph_sbox;
						round_q <= '0;
						decrypt_q <= (in_mode == mode_decrypt);
					end
				end
				ph_sbox: begin
					phase <= ph_mix;
				end
				ph_mix: begin
					if (last_round) begin
						phase <= ph_done;
					end else begin
						phase <= ph_sbox;
						round_q <= round_q + 4'd1;
					end
				end
				ph_done: begin
					if (out_valid) begin
						phase <= ph_load;
					end
				end
				default: begin
					phase <= ph_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sink_cnt <= cnt_w'(SINK_CREDITS);
		end else if (out_credit && !out_valid) begin
			sink_cnt <= sink_cnt + 1'b1;
		end else if (out_valid && !out_credit) begin
			sink_cnt <= sink_cnt - 1'b1;
		end
	end

	// a block may only arrive after the credit for it was granted
	assert property (@(posedge clk) disable iff (!rst_n) in_valid |-> phase == ph_load)
		else $error("in_valid arrived while the engine was busy");

	assert property (@(posedge clk) disable iff (!rst_n) sink_cnt <= SINK_CREDITS)
		else $error("sink credit count above its limit");

	assert property (@(posedge clk) disable iff (!rst_n) out_credit |-> sink_cnt < SINK_CREDITS)
		else $error("sink returned a credit it did not hold");

endmodule

// ==== des_engine_top.sv ====
`timescale 1ns/1ps

module des_engine_top #(
	parameter int SINK_CREDITS = 2
) (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic [des_types_pkg::block_w-1:0] in_block,
	input logic [des_types_pkg::block_w-1:0] in_key,
	input des_types_pkg::des_mode_e in_mode,
	output logic in_credit,
	output logic out_valid,
	output logic [des_types_pkg::block_w-1:0] out_block,
	input logic out_credit
);
	import des_types_pkg::*;

	logic load;
	logic step_sbox;
	logic step_mix;
	logic unload;
	logic key_step;
	logic decrypt;
	logic [3:0] round_idx;
	logic [subkey_w-1:0] subkey;
	logic [subkey_w-1:0] mixed;
	logic [half_w-1:0] sbox_out;

	des_control #(
		.SINK_CREDITS(SINK_CREDITS)
	) u_control (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_credit(in_credit),
		.out_credit(out_credit),
		.out_valid(out_valid),
		.load(load),
		.step_sbox(step_sbox),
		.step_mix(step_mix),
		.unload(unload),
		.key_step(key_step),
		.round_idx(round_idx),
		.decrypt(decrypt),
		.in_mode(in_mode)
	);

	des_round u_round (
		.clk(clk),
		.rst_n(rst_n),
		.load(load),
		.step_sbox(step_sbox),
		.step_mix(step_mix),
		.unload(unload),
		.block_in(in_block),
		.subkey(subkey),
		.sbox_out(sbox_out),
		.mixed(mixed),
		.block_out(out_block)
	);

	des_key_schedule u_keys (
		.clk(clk),
		.rst_n(rst_n),
		.load(load),
		.decrypt(decrypt),
		.step(key_step),
		.round_idx(round_idx),
		.key(in_key),
		.subkey(subkey)
	);

	des_sbox_bank u_sbox (
		.clk(clk),
		.mixed(mixed),
		.sbox_out(sbox_out)
	);

endmodule

// ==== des_key_schedule.sv ====
`timescale 1ns/1ps

module des_key_schedule (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic decrypt,
	input logic step,
	input logic [3:0] round_idx,
	input logic [des_types_pkg::block_w-1:0] key,
	output logic [des_types_pkg::subkey_w-1:0] subkey
);
	import des_tables_pkg::*;

	logic [55:0] pc1_out;
	logic [55:0] cd;
	logic [27:0] c_q;
	logic [27:0] d_q;
	logic [3:0] next_idx;
	logic [3:0] back_idx;

	function automatic logic [27:0] rotate(input logic [27:0] x, input logic left, input int amt);
		if (left) begin
			return (x << amt) | (x >> (28 - amt));
		end
		return (x >> amt) | (x << (28 - amt));
	endfunction

	always_comb begin
		for (int j = 0; j < 56; j++) begin
			pc1_out[55-j] = key[64-pc1_tab[j]];
		end
	end

	assign cd = {c_q, d_q};

	always_comb begin
		for (int j = 0; j < 48; j++) begin
			subkey[47-j] = cd[56-pc2_tab[j]];
		end
	end

	assign next_idx = round_idx + 4'd1; // wraps after the last round, where the value is unused
	assign back_idx = 4'd15 - round_idx;

	always_ff @(posedge clk) begin
		if (load) begin
			if (decrypt) begin
				c_q <= pc1_out[55:28]; // C0 equals C16, so decryption starts from here
				d_q <= pc1_out[27:0];
			end else begin
				c_q <= rotate(pc1_out[55:28], 1'b1, shift_tab[0]);
				d_q <= rotate(pc1_out[27:0], 1'b1, shift_tab[0]);
			end
		end else if (step) begin
			if (decrypt) begin
				c_q <= rotate(c_q, 1'b0, shift_tab[back_idx]);
				d_q <= rotate(d_q, 1'b0, shift_tab[back_idx]);
			end else begin
				c_q <= rotate(c_q, 1'b1, shift_tab[next_idx]);
				d_q <= rotate(d_q, 1'b1, shift_tab[next_idx]);
			end
		end
	end

	// the direction latched at load must hold for every rotation of the block
	assert property (@(posedge clk) disable iff (!rst_n) step |-> $stable(decrypt))
		else $error("key schedule direction changed during a block");

endmodule

// ==== des_round.sv ====
`timescale 1ns/1ps

module des_round (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic step_sbox,
	input logic step_mix,
	input logic unload,
	input logic [des_types_pkg::block_w-1:0] block_in,
	input logic [des_types_pkg::subkey_w-1:0] subkey,
	input logic [des_types_pkg::half_w-1:0] sbox_out,
	output logic [des_types_pkg::subkey_w-1:0] mixed,
	output logic [des_types_pkg::block_w-1:0] block_out
);
	import des_types_pkg::*;
	import des_tables_pkg::*;

	des_block_u state_q;
	des_block_u ip_out;
	des_block_u next_state;
	des_block_u swapped;
	logic [subkey_w-1:0] expanded;
	logic [half_w-1:0] f_out;
	logic [block_w-1:0] fp_out;

	always_comb begin
		for (int j = 0; j < block_w; j++) begin
			ip_out.raw[block_w-1-j] = block_in[block_w-ip_tab[j]];
		end
	end

	always_comb begin
		for (int j = 0; j < subkey_w; j++) begin
			expanded[subkey_w-1-j] = state_q.half.r[half_w-e_tab[j]];
		end
	end

	assign mixed = step_sbox ? (expanded ^ subkey) : '0; // keeps the s-box inputs quiet between rounds

	always_comb begin
		for (int j = 0; j < half_w; j++) begin
			f_out[half_w-1-j] = sbox_out[half_w-p_tab[j]];
		end
	end

	always_comb begin
		next_state.half.l = state_q.half.r;
		next_state.half.r = state_q.half.l ^ f_out;
		swapped.half.l = next_state.half.r; // the last round leaves its halves swapped
		swapped.half.r = next_state.half.l;
		for (int j = 0; j < block_w; j++) begin
			fp_out[block_w-1-j] = swapped.raw[block_w-fp_tab[j]];
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			state_q.raw <= ip_out.raw;
		end else if (step_mix) begin
			state_q <= next_state;
		end
		if (unload) begin
			block_out <= fp_out; // taken with the last mix so the result is ready in the done phase
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) !(step_sbox && step_mix))
		else $error("des_round saw sbox and mix phases in the same cycle");

endmodule

// ==== des_sbox_bank.sv ====
`timescale 1ns/1ps

module des_sbox_bank (
	input logic clk,
	input logic [des_types_pkg::subkey_w-1:0] mixed,
	output logic [des_types_pkg::half_w-1:0] sbox_out
);
	import des_tables_pkg::*;

	logic [0:7][5:0] sel;

	// row is the outer bit pair, column the middle four bits
	always_comb begin
		for (int g = 0; g < 8; g++) begin
			sel[g] = {mixed[47-6*g], mixed[42-6*g], mixed[46-6*g -: 4]};
		end
	end

	always_ff @(posedge clk) begin
		for (int g = 0; g < 8; g++) begin
			sbox_out[31-4*g -: 4] <= sbox_tab[g][sel[g]]; // group 1 lands in the top nibble
		end
	end

endmodule

// ==== des_tables_pkg.sv ====
package des_tables_pkg;

	// all entries use the standard 1-based numbering, bit 1 is the msb

	localparam int ip_tab [64] = '{
		58, 50, 42, 34, 26, 18, 10, 2,
		60, 52, 44, 36, 28, 20, 12, 4,
		62, 54, 46, 38, 30, 22, 14, 6,
		64, 56, 48, 40, 32, 24, 16, 8,
		57, 49, 41, 33, 25, 17, 9, 1,
		59, 51, 43, 35, 27, 19, 11, 3,
		61, 53, 45, 37, 29, 21, 13, 5,
		63, 55, 47, 39, 31, 23, 15, 7
	};

	localparam int fp_tab [64] = '{
		40, 8, 48, 16, 56, 24, 64, 32,
		39, 7, 47, 15, 55, 23, 63, 31,
		38, 6, 46, 14, 54, 22, 62, 30,
		37, 5, 45, 13, 53, 21, 61, 29,
		36, 4, 44, 12, 52, 20, 60, 28,
		35, 3, 43, 11, 51, 19, 59, 27,
		34, 2, 42, 10, 50, 18, 58, 26,
		33, 1, 41, 9, 49, 17, 57, 25
	};

	localparam int e_tab [48] = '{
		32, 1, 2, 3, 4, 5,
		4, 5, 6, 7, 8, 9,
		8, 9, 10, 11, 12, 13,
		12, 13, 14, 15, 16, 17,
		16, 17, 18, 19, 20, 21,
		20, 21, 22, 23, 24, 25,
		24, 25, 26, 27, 28, 29,
		28, 29, 30, 31, 32, 1
	};

	localparam int p_tab [32] = '{
		16, 7, 20, 21, 29, 12, 28, 17,
		1, 15, 23, 26, 5, 18, 31, 10,
		2, 8, 24, 14, 32, 27, 3, 9,
		19, 13, 30, 6, 22, 11, 4, 25
	};

	localparam int pc1_tab [56] = '{
		57, 49, 41, 33, 25, 17, 9,
		1, 58, 50, 42, 34, 26, 18,
		10, 2, 59, 51, 43, 35, 27,
		19, 11, 3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15,
		7, 62, 54, 46, 38, 30, 22,
		14, 6, 61, 53, 45, 37, 29,
		21, 13, 5, 28, 20, 12, 4
	};

	localparam int pc2_tab [48] = '{
		14, 17, 11, 24, 1, 5,
		3, 28, 15, 6, 21, 10,
		23, 19, 12, 4, 26, 8,
		16, 7, 27, 20, 13, 2,
		41, 52, 31, 37, 47, 55,
		30, 40, 51, 45, 33, 48,
		44, 49, 39, 56, 34, 53,
		46, 42, 50, 36, 29, 32
	};

	localparam int shift_tab [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

	// table g, entry row*16+col, entry 0 is the leftmost nibble
	localparam logic [0:7][0:63][3:0] sbox_tab = {
		256'hE4D12FB83A6C5907_0F74E2D1A6CB9538_41E8D62BFC973A50_FC8249175B3EA06D,
		256'hF18E6B34972DC05A_3D47F28EC01A69B5_0E7BA4D158C6932F_D8A13F42B67C05E9,
		256'hA09E63F51DC7B428_D709346A285ECBF1_D6498F30B12C5AE7_1AD069874FE3B52C,
		256'h7DE3069A1285BC4F_D8B56F03472C1AE9_A690CB7DF13E5284_3F06A1D8945BC72E,
		256'h2C417AB6853FD0E9_EB2C47D150FA3986_421BAD78F9C5630E_B8C71E2D6F09A453,
		256'hC1AF92680D34E75B_AF427C9561DE0B38_9EF528C3704A1DB6_432C95FABE17608D,
		256'h4B2EF08D3C975A61_D0B7491AE35C2F86_14BDC37EAF680592_6BD814A7950FE23C,
		256'hD2846FB1A93E50C7_1FD8A374C56B0E92_7B419CE206ADF358_21E74A8DFC90356B
	};

endpackage

// ==== des_types_pkg.sv ====
package des_types_pkg;

	localparam int block_w = 64;
	localparam int half_w = 32;
	localparam int subkey_w = 48;

	// left half sits in the upper 32 bits, as in the DES bit numbering
	typedef struct packed {
		logic [half_w-1:0] l;
		logic [half_w-1:0] r;
	} des_halves_t;

	// permutations work on the raw word, the Feistel update on the halves
	typedef union packed {
		logic [block_w-1:0] raw;
		des_halves_t half;
	} des_block_u;

	typedef enum logic {
		mode_encrypt = 1'b0,
		mode_decrypt = 1'b1
	} des_mode_e;

	// five phases need three bits
	typedef enum logic [2:0] {
		ph_idle = 3'd0, // first cycle out of reset
		ph_load = 3'd1, // credit granted, waiting for a block
		ph_sbox = 3'd2,
		ph_mix = 3'd3,
		ph_done = 3'd4  // result held until a sink credit is available
	} des_phase_e;

endpackage

// ==== tb_des_engine.sv ====
`timescale 1ns/1ps

module tb_des_engine;
	import des_types_pkg::*;

	localparam int wait_limit = 200;
	localparam logic [63:0] known_pt = 64'h0123456789ABCDEF;
	localparam logic [63:0] known_key = 64'h133457799BBCDFF1;
	localparam logic [63:0] known_ct = 64'h85E813540F0AB405;
	localparam logic [63:0] weak_key = 64'h0101010101010101;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic [block_w-1:0] in_block;
	logic [block_w-1:0] in_key;
	des_mode_e in_mode;
	logic in_credit;
	logic out_valid;
	logic [block_w-1:0] out_block;
	logic out_credit;

	int cycle_cnt = 0;
	int src_credits = 0; // input credits granted by the engine and not yet used
	int credit_total = 0;
	int last_credit_cycle = -1;
	int rst_cycle = 0;
	int value_errs = 0;
	int proto_errs = 0;
	logic [block_w-1:0] result_q[$];
	int result_cycle_q[$];

	des_engine_top #(
		.SINK_CREDITS(2)
	) u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_block(in_block),
		.in_key(in_key),
		.in_mode(in_mode),
		.in_credit(in_credit),
		.out_valid(out_valid),
		.out_block(out_block),
		.out_credit(out_credit)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clk) begin
		if (rst_n === 1'b1) begin
			if (in_credit === 1'b1) begin
				assert (src_credits == 0) else begin
					proto_errs++;
					$display("engine granted an input credit at %0t ns while one was still held",
						$time);
				end
				src_credits++;
				credit_total++;
				last_credit_cycle = cycle_cnt;
			end
			if (out_valid === 1'b1) begin
				result_q.push_back(out_block);
				result_cycle_q.push_back(cycle_cnt);
			end
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic compare_block(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp) else begin
			value_errs++;
			$display("FAILED at %0t ns: %s returned %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_int(input string what, input int got, input int exp);
		assert (got == exp) else begin
			value_errs++;
			$display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic wait_in_credit(output bit ok);
		int n;
		n = 0;
		while (src_credits == 0 && n < wait_limit) begin
			next_cycle();
			n++;
		end
		ok = (src_credits > 0);
		assert (ok) else begin
			proto_errs++;
			$display("timed out at %0t ns waiting for an input credit", $time);
		end
	endtask

	task automatic send_block(input logic [63:0] blk, input logic [63:0] key,
			input des_mode_e mode, output int in_cyc);
		bit ok;
		in_cyc = -1;
		wait_in_credit(ok);
		if (ok) begin
			in_block = blk;
			in_key = key;
			in_mode = mode;
			in_valid = 1'b1;
			src_credits--;
			in_cyc = cycle_cnt;
			next_cycle();
			in_valid = 1'b0;
		end
	endtask

	task automatic get_result(output logic [63:0] blk, output int out_cyc);
		int n;
		n = 0;
		while (result_q.size() == 0 && n < wait_limit) begin
			next_cycle();
			n++;
		end
		assert (result_q.size() > 0) else begin
			proto_errs++;
			$display("timed out at %0t ns waiting for out_valid", $time);
		end
		if (result_q.size() > 0) begin
			blk = result_q.pop_front();
			out_cyc = result_cycle_q.pop_front();
		end else begin
			blk = '0;
			out_cyc = -1;
		end
	endtask

	task automatic return_credit(output int credit_cyc);
		out_credit = 1'b1;
		credit_cyc = cycle_cnt;
		next_cycle();
		out_credit = 1'b0;
	endtask

	// full round through the engine with the sink credit handed straight back
	task automatic run_block(input logic [63:0] blk, input logic [63:0] key,
			input des_mode_e mode, output logic [63:0] res);
		int in_cyc;
		int out_cyc;
		int credit_cyc;
		send_block(blk, key, mode, in_cyc);
		get_result(res, out_cyc);
		return_credit(credit_cyc);
	endtask

	task automatic test_input_credit();
		logic [63:0] res;
		int in_cyc;
		int out_cyc;
		int credit_cyc;
		bit ok;
		repeat (6) next_cycle();
		compare_int("input credits after reset", credit_total, 1);
		compare_int("cycles from reset release to first credit", last_credit_cycle - rst_cycle, 1);
		send_block(known_pt, known_key, mode_encrypt, in_cyc);
		get_result(res, out_cyc);
		compare_int("input credits before out_valid", credit_total, 1);
		compare_block("encrypt after reset", res, known_ct);
		wait_in_credit(ok);
		compare_int("cycles from out_valid to next credit", last_credit_cycle - out_cyc, 1);
		return_credit(credit_cyc);
	endtask

	task automatic test_known_vector();
		logic [63:0] res;
		run_block(known_pt, known_key, mode_encrypt, res);
		compare_block("known vector encrypt", res, known_ct);
		run_block(known_ct, known_key, mode_decrypt, res);
		compare_block("known vector decrypt", res, known_pt);
	endtask

	task automatic test_round_trip();
		des_block_u pt;
		logic [63:0] key;
		logic [63:0] ct;
		logic [63:0] back;
		for (int i = 0; i < 20; i++) begin
			pt.half.l = $urandom();
			pt.half.r = $urandom();
			key = {$urandom(), $urandom()};
			run_block(pt.raw, key, mode_encrypt, ct);
			run_block(ct, key, mode_decrypt, back);
			compare_block("random round trip", back, pt.raw);
		end
	endtask

	// every subkey of a weak key is the same, so encryption is its own inverse
	task automatic test_weak_key();
		des_block_u pt;
		logic [63:0] once;
		logic [63:0] twice;
		pt.half.l = $urandom();
		pt.half.r = $urandom();
		run_block(pt.raw, weak_key, mode_encrypt, once);
		run_block(once, weak_key, mode_encrypt, twice);
		compare_block("double encryption under weak key", twice, pt.raw);
	endtask

	task automatic test_back_pressure();
		logic [63:0] res;
		int in_cyc;
		int out_cyc;
		int credit_cyc;
		send_block(known_pt, known_key, mode_encrypt, in_cyc);
		get_result(res, out_cyc);
		compare_block("first result under back-pressure", res, known_ct);
		compare_int("latency of first result", out_cyc - in_cyc, 33);
		send_block(known_ct, known_key, mode_decrypt, in_cyc);
		get_result(res, out_cyc);
		compare_block("second result under back-pressure", res, known_pt);
		compare_int("latency of second result", out_cyc - in_cyc, 33);
		send_block(known_pt, known_key, mode_encrypt, in_cyc);
		repeat (133) next_cycle(); // done at 33, then 100 cycles held
		compare_int("results sent without a sink credit", result_q.size(), 0);
		return_credit(credit_cyc);
		get_result(res, out_cyc);
		compare_block("held result after credit", res, known_ct);
		compare_int("cycles from sink credit to held result", out_cyc - credit_cyc, 1);
		return_credit(credit_cyc);
		return_credit(credit_cyc);
	endtask

	initial begin
		void'($urandom(32'h2a70_d681));
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_block = '0;
		in_key = '0;
		in_mode = mode_encrypt;
		out_credit = 1'b0;
		repeat (4) next_cycle();
		rst_n = 1'b1;
		rst_cycle = cycle_cnt;
		test_input_credit();
		test_known_vector();
		test_round_trip();
		test_weak_key();
		test_back_pressure();
		repeat (4) next_cycle();
		$display("value errors: %0d, protocol and timeout errors: %0d", value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
